// File: prefetch_fifo_params.svh
// prefetch FIFO parameters
// RAM depth, payload width and almost thresholds
`ifndef PREFETCH_FIFO_PARAMS_SVH
`define PREFETCH_FIFO_PARAMS_SVH

////////////////////////////////////////
// RAM geometry
////////////////////////////////////////
`define FIFO_ADDR_W        4                    // 16 words in RAM
`define FIFO_DEPTH         (1 << `FIFO_ADDR_W)  // derived word count
`define FIFO_DATA_W        32                   // payload bits

////////////////////////////////////////
// level thresholds, RAM words only
////////////////////////////////////////
`define FIFO_ALMOST_FULL   14                   // almost_full at or above
`define FIFO_ALMOST_EMPTY  2                    // almost_empty at or below

`endif

// File: prefetch_fifo_pkg.sv
// prefetch FIFO types
// stored word, fill status and output stage occupancy
`default_nettype none

`include "prefetch_fifo_params.svh"

package prefetch_fifo_pkg;

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////
  typedef struct packed
  {
    logic                    last;  // frame marker
    logic [`FIFO_DATA_W-1:0] data;  // payload word
  } fifo_entry_t;

  ////////////////////////////////////////
  // fill status
  ////////////////////////////////////////
  typedef struct packed
  {
    logic                  not_full;      // RAM can take a word
    logic                  almost_full;   // level at threshold or above
    logic                  almost_empty;  // level at threshold or below
    logic [`FIFO_ADDR_W:0] level;         // words in RAM, not output stage
  } fifo_status_t;

  // output stage occupancy
  typedef enum logic [1:0]
  {
    OUT_EMPTY = 2'd0,  // nothing held
    OUT_ONE   = 2'd1,  // head valid
    OUT_TWO   = 2'd2   // head and tail valid
  } out_state_e;

endpackage

`default_nettype wire

// File: fifo_sdpram.sv
// simple dual-port RAM for the FIFO
// one write port, one registered read port loaded on read enable
`timescale 1ns/1ps
`default_nettype none

module fifo_sdpram #(
  parameter int  ADDR_W  = 4,           // address bits
  parameter type entry_t = logic [7:0]  // stored word type
) (
  input  logic              rd_clk,    // single clock for both ports
  input  logic              wr_en,     // already qualified by caller
  input  logic [ADDR_W-1:0] wr_addr,
  input  entry_t            wr_entry,
  input  logic              rd_en,     // loads output register
  input  logic [ADDR_W-1:0] rd_addr,
  output entry_t            rd_entry   // held while rd_en low
);

  localparam int DEPTH = 1 << ADDR_W;  // full address space

  entry_t mem [DEPTH];  // storage array, no reset

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////
  always_ff @(posedge rd_clk)
  begin
    if (wr_en)
    begin
      mem[wr_addr] <= wr_entry;  // visible to a read at next edge
    end
  end

  ////////////////////////////////////////
  // read port
  ////////////////////////////////////////
  always_ff @(posedge rd_clk)
  begin
    if (rd_en)
    begin
      rd_entry <= mem[rd_addr];  // one cycle latency
    end
  end

endmodule

`default_nettype wire

// File: fifo_ctrl.sv
// FIFO pointer controller
// write and read pointers, empty flag, level and almost flags
// pointers carry one extra wrap bit to tell full from empty
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_fifo_params.svh"

module fifo_ctrl (
  input  logic                             rd_clk,
  input  logic                             rd_rst,
  input  logic                             wr_en,    // qualified with not_full
  output logic [`FIFO_ADDR_W-1:0]          wr_addr,
  input  logic                             rd_en,    // prefetch read
  output logic [`FIFO_ADDR_W-1:0]          rd_addr,
  output logic                             empty,
  output prefetch_fifo_pkg::fifo_status_t  status
);

  localparam int ADDR_W = `FIFO_ADDR_W;

  // thresholds sized to the level field
  localparam logic [ADDR_W:0] AF_LVL   = (ADDR_W + 1)'(`FIFO_ALMOST_FULL);
  localparam logic [ADDR_W:0] AE_LVL   = (ADDR_W + 1)'(`FIFO_ALMOST_EMPTY);

  logic [ADDR_W:0] wr_ptr_q;  // msb is wrap bit
  logic [ADDR_W:0] rd_ptr_q;
  logic [ADDR_W:0] level;     // words held in RAM
  logic            full;

  ////////////////////////////////////////
  // pointers
  ////////////////////////////////////////
  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      if (wr_en)
      begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps through msb
      end
      if (rd_en)
      begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  assign wr_addr = wr_ptr_q[ADDR_W-1:0];  // drop wrap bit
  assign rd_addr = rd_ptr_q[ADDR_W-1:0];

  ////////////////////////////////////////
  // flags and level
  ////////////////////////////////////////
  // low bits equal: same slot, wrap bit decides full or empty
  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                 (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);
  assign level = wr_ptr_q - rd_ptr_q;  // modulo difference

  assign status.not_full     = ~full;
  assign status.almost_full  = (level >= AF_LVL);
  assign status.almost_empty = (level <= AE_LVL);
  assign status.level        = level;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  // the top level must gate writes with not_full
  a_no_write_full : assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    wr_en |-> !full
  ) else $error("write while RAM full");

  // prefetch must only read a non-empty RAM
  a_no_read_empty : assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    rd_en |-> !empty
  ) else $error("read while RAM empty");

endmodule

`default_nettype wire

// File: fifo_out_stage.sv
// two-entry register FIFO in front of the reader
// head slot always drives the output, tail catches a second word
`timescale 1ns/1ps
`default_nettype none

module fifo_out_stage #(
  parameter type entry_t = logic [7:0]  // word type
) (
  input  logic   rd_clk,
  input  logic   rd_rst,
  input  logic   in_vld,     // push, no ready needed
  input  entry_t in_entry,
  input  logic   out_rdy,    // reader takes head
  output logic   out_vld,
  output entry_t out_entry
);

  import prefetch_fifo_pkg::*;

  out_state_e state_q;
  out_state_e state_d;
  entry_t     head_q;          // oldest word
  entry_t     tail_q;          // second word
  logic       push;
  logic       pop;
  logic       head_ld;
  logic       head_from_tail;  // shift tail forward
  logic       tail_ld;

  assign push = in_vld;
  assign pop  = out_vld & out_rdy;

  ////////////////////////////////////////
  // occupancy FSM
  ////////////////////////////////////////
  always_comb
  begin
    state_d        = state_q;
    head_ld        = 1'b0;
    head_from_tail = 1'b0;
    tail_ld        = 1'b0;
    case (state_q)
      OUT_EMPTY:
      begin
        if (push)
        begin
          head_ld = 1'b1;       // straight into head
          state_d = OUT_ONE;
        end
      end
      OUT_ONE:
      begin
        if (push && pop)
        begin
          head_ld = 1'b1;       // replace head
        end
        else if (push)
        begin
          tail_ld = 1'b1;       // queue behind head
          state_d = OUT_TWO;
        end
        else if (pop)
        begin
          state_d = OUT_EMPTY;
        end
      end
      OUT_TWO:
      begin
        if (pop)
        begin
          head_ld        = 1'b1;
          head_from_tail = 1'b1;
          tail_ld        = push;  // refill tail on same edge
          state_d        = push ? OUT_TWO : OUT_ONE;
        end
      end
      default:
      begin
        state_d = OUT_EMPTY;    // illegal encoding
      end
    endcase
  end

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      state_q <= OUT_EMPTY;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // slots
  ////////////////////////////////////////
  always_ff @(posedge rd_clk)
  begin
    if (head_ld)
    begin
      head_q <= head_from_tail ? tail_q : in_entry;
    end
    if (tail_ld)
    begin
      tail_q <= in_entry;
    end
  end

  assign out_vld   = (state_q != OUT_EMPTY);
  assign out_entry = head_q;                  // stable until popped

  // upstream credit must keep the stage from overflowing
  a_no_overflow : assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    (push && state_q == OUT_TWO) |-> pop
  ) else $error("push into full output stage");

endmodule

`default_nettype wire

// File: prefetch_fifo.sv
// prefetching FIFO top level
// RAM and pointer controller behind a two-word output stage
// credit logic issues RAM reads ahead of the reader
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_fifo_params.svh"

module prefetch_fifo (
  input  logic                             rd_clk,
  input  logic                             rd_rst,
  input  logic                             wr_en,
  input  prefetch_fifo_pkg::fifo_entry_t   wr_entry,
  output logic                             wr_vld,    // room in RAM
  input  logic                             rd_en,
  output prefetch_fifo_pkg::fifo_entry_t   rd_entry,
  output logic                             rd_vld,    // word waiting
  output prefetch_fifo_pkg::fifo_status_t  status
);

  import prefetch_fifo_pkg::*;

  logic [`FIFO_ADDR_W-1:0] wr_addr;
  logic [`FIFO_ADDR_W-1:0] rd_addr;
  logic                    wr_acc;     // accepted write
  logic                    ram_empty;
  logic                    pf_rd;      // prefetch read this cycle
  logic                    pf_vld_q;   // RAM data valid, pairs with pf_rd
  logic                    pop;        // reader takes a word
  logic [1:0]              credit_q;   // in flight plus held, 0..2
  fifo_entry_t             ram_entry;

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////
  assign wr_vld = status.not_full;
  assign wr_acc = wr_en & wr_vld;  // ignore writes while full

  ////////////////////////////////////////
  // prefetch credit
  ////////////////////////////////////////
  assign pop   = rd_vld & rd_en;
  // a pop frees a slot on the same edge
  assign pf_rd = ~ram_empty & ((credit_q < 2'd2) | pop);

  always_ff @(posedge rd_clk or posedge rd_rst)
  begin
    if (rd_rst)
    begin
      credit_q <= 2'd0;
      pf_vld_q <= 1'b0;
    end
    else
    begin
      pf_vld_q <= pf_rd;  // RAM read latency
      case ({pf_rd, pop})
        2'b10:   credit_q <= credit_q + 2'd1;
        2'b01:   credit_q <= credit_q - 2'd1;
        default: credit_q <= credit_q;  // both or neither
      endcase
    end
  end

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////
  fifo_sdpram #(
    .ADDR_W  (`FIFO_ADDR_W),
    .entry_t (fifo_entry_t)
  ) i_ram (
    .rd_clk   (rd_clk),
    .wr_en    (wr_acc),
    .wr_addr  (wr_addr),
    .wr_entry (wr_entry),
    .rd_en    (pf_rd),      // only load on prefetch
    .rd_addr  (rd_addr),
    .rd_entry (ram_entry)
  );

  fifo_ctrl i_ctrl (
    .rd_clk  (rd_clk),
    .rd_rst  (rd_rst),
    .wr_en   (wr_acc),
    .wr_addr (wr_addr),
    .rd_en   (pf_rd),       // pointer advance with RAM read
    .rd_addr (rd_addr),
    .empty   (ram_empty),
    .status  (status)
  );

  fifo_out_stage #(
    .entry_t (fifo_entry_t)
  ) i_out (
    .rd_clk    (rd_clk),
    .rd_rst    (rd_rst),
    .in_vld    (pf_vld_q),
    .in_entry  (ram_entry),
    .out_rdy   (rd_en),
    .out_vld   (rd_vld),
    .out_entry (rd_entry)
  );

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  a_credit_max : assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    credit_q <= 2'd2
  ) else $error("prefetch credit above 2");

  // a word at the output is always counted in the credit
  a_pop_counted : assert property (
    @(posedge rd_clk) disable iff (rd_rst)
    pop |-> (credit_q != 2'd0)
  ) else $error("pop without credit");

endmodule

`default_nettype wire

// File: tb_prefetch_fifo.sv
// prefetch FIFO testbench
// random writes and reads from an LFSR, checked against a queue model
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_fifo_params.svh"

module tb_prefetch_fifo;

  import prefetch_fifo_pkg::*;

  localparam int RESET_CYCLES = 8;
  localparam int PHASE_CYCLES = 400;
  localparam int DRAIN_MARGIN = 92;   // drain plus final single-word check
  localparam int CYCLE_LIMIT  = RESET_CYCLES + 3 * PHASE_CYCLES + DRAIN_MARGIN;
  localparam int MAX_WAIT     = 4;    // rd_vld rise after write into empty FIFO

  logic         rd_clk = 1'b0;
  logic         rd_rst;
  logic         wr_en;
  fifo_entry_t  wr_entry;
  logic         wr_vld;
  logic         rd_en;
  fifo_entry_t  rd_entry;
  logic         rd_vld;
  fifo_status_t status;

  fifo_entry_t  model [$];           // expected contents, oldest first
  logic [31:0]  lfsr_q;
  int           phase;               // 0 fill, 1 drain, 2 balanced
  int           cycle_cnt = 0;
  logic         seen_full = 1'b0;    // wr_vld low seen in fill phase
  logic         stall_q   = 1'b0;    // word held, not taken last edge
  fifo_entry_t  held_q;
  int           wait_cnt;

  always #20 rd_clk = ~rd_clk;       // 40 ns period

  prefetch_fifo i_dut (
    .rd_clk   (rd_clk),
    .rd_rst   (rd_rst),
    .wr_en    (wr_en),
    .wr_entry (wr_entry),
    .wr_vld   (wr_vld),
    .rd_en    (rd_en),
    .rd_entry (rd_entry),
    .rd_vld   (rd_vld),
    .status   (status)
  );

  ////////////////////////////////////////
  // failure and compare tasks
  ////////////////////////////////////////
  task automatic end_on_failure();
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_entry(input string name, input fifo_entry_t exp, input fifo_entry_t act);
    if (exp !== act)
    begin
      $display("Mismatch %s: expected last=%0b data=%h actual last=%0b data=%h",
               name, exp.last, exp.data, act.last, act.data);
      end_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("Mismatch %s: expected %0b actual %0b", name, exp, act);
      end_on_failure();
    end
  endtask

  // level counts RAM words only, up to two more sit past the RAM
  task automatic check_level(input string name, input int count, input fifo_status_t st);
    if ((int'(st.level) < count - 2) || (int'(st.level) > count))
    begin
      $display("Mismatch %s: expected %0d..%0d actual %0d",
               name, count - 2, count, int'(st.level));
      end_on_failure();
    end
  endtask

  ////////////////////////////////////////
  // random source
  ////////////////////////////////////////
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);  // galois, right shift
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};  // one step per bit
    end
  endtask

  // quarters: chance out of 4 that the enable is set
  task automatic drive_random(input int wr_quarters, input int rd_quarters);
    logic [31:0] bits;
    take_bits(2, bits);
    wr_en = (int'(bits) < wr_quarters);
    take_bits(2, bits);
    rd_en = (int'(bits) < rd_quarters);
    take_bits(32, bits);
    wr_entry.data = bits;
    take_bits(1, bits);
    wr_entry.last = bits[0];
  endtask

  task automatic run_phase(input int wr_quarters, input int rd_quarters);
    for (int i = 0; i < PHASE_CYCLES; i++)
    begin
      drive_random(wr_quarters, rd_quarters);
      @(posedge rd_clk);
      #2;
    end
  endtask

  ////////////////////////////////////////
  // monitor, sampled mid-cycle
  ////////////////////////////////////////
  task automatic check_status(input int count);
    if (count == 0)
      check_bit("rd_vld with empty model", 1'b0, rd_vld);
    if (count < `FIFO_DEPTH)
      check_bit("wr_vld below capacity", 1'b1, wr_vld);
    if (count == `FIFO_DEPTH + 2)
      check_bit("wr_vld at capacity", 1'b0, wr_vld);
    check_level("status.level", count, status);
    if (int'(status.level) < `FIFO_ALMOST_FULL)
      check_bit("almost_full below threshold", 1'b0, status.almost_full);
    if (int'(status.level) > `FIFO_ALMOST_EMPTY)
      check_bit("almost_empty above threshold", 1'b0, status.almost_empty);
  endtask

  always @(negedge rd_clk)
  begin
    if (!rd_rst)
    begin
      check_status(model.size());
      if (stall_q)                                   // no pop at last edge
      begin
        check_bit("stall rd_vld", 1'b1, rd_vld);
        check_entry("stall rd_entry", held_q, rd_entry);
      end
      if (phase == 0 && !wr_vld)
        seen_full = 1'b1;
      if (rd_vld && rd_en)                           // pop at next edge
      begin
        check_entry("pop order", model[0], rd_entry);
        void'(model.pop_front());
      end
      if (wr_en && wr_vld)                           // write at next edge
        model.push_back(wr_entry);
      stall_q = rd_vld && !rd_en;
      held_q  = rd_entry;
    end
  end

  always @(posedge rd_clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
      end_on_failure();
    end
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial
  begin
    rd_rst   = 1'b1;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_entry = '0;
    lfsr_q   = 32'h93b785d3;
    phase    = 0;
    repeat (RESET_CYCLES) @(posedge rd_clk);
    #2;
    rd_rst = 1'b0;

    run_phase(3, 1);                                 // fill-biased
    if (!seen_full)
    begin
      $display("Error: wr_vld never dropped during the fill phase");
      end_on_failure();
    end
    phase = 1;
    run_phase(1, 3);                                 // drain-biased
    phase = 2;
    run_phase(2, 2);                                 // balanced

    // drain everything left
    wr_en = 1'b0;
    rd_en = 1'b1;
    while (model.size() != 0)
      @(posedge rd_clk);
    #2;
    rd_en = 1'b0;

    // one word into an empty FIFO must show up at the output
    wr_entry = '{last: 1'b1, data: 32'h5a5aa5a5};
    wr_en    = 1'b1;
    @(posedge rd_clk);
    #2;
    wr_en = 1'b0;
    for (wait_cnt = 0; wait_cnt < MAX_WAIT && !rd_vld; wait_cnt++)
      @(negedge rd_clk);
    if (!rd_vld)
    begin
      $display("Error: rd_vld stayed low %0d cycles after a write into an empty FIFO",
               MAX_WAIT);
      end_on_failure();
    end
    @(posedge rd_clk);
    #2;
    rd_en = 1'b1;                                    // take the word
    @(posedge rd_clk);
    #2;
    rd_en = 1'b0;
    @(negedge rd_clk);

    if (model.size() != 0)
    begin
      $display("Error: %0d words left in the model after the final drain", model.size());
      end_on_failure();
    end
    else
    begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
prefetch_fifo_pkg.sv
fifo_sdpram.sv
fifo_ctrl.sv
fifo_out_stage.sv
prefetch_fifo.sv
tb_prefetch_fifo.sv

// File: Makefile
# Verilator build for the prefetch FIFO testbench
TOP := tb_prefetch_fifo

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
